//--- common/gpu_pkg.sv
// GPU core pipeline package
// sizes, ALU opcodes and the structs that travel between the
// scoreboard, operand collector and ALU stages
`default_nettype none

package gpu_pkg;

    localparam int num_warps   = 4;
    localparam int num_threads = 4;
    localparam int num_regs    = 32;
    localparam int xlen        = 32;

    localparam int wid_w      = $clog2(num_warps);
    localparam int reg_w      = $clog2(num_regs);
    localparam int gpr_addr_w = wid_w + reg_w;

    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul,
        op_madd
    } alu_op_e;

    typedef logic [num_threads-1:0] tmask_t;
    typedef logic [xlen-1:0] word_t;
    typedef word_t [num_threads-1:0] thread_data_t;

    typedef struct packed {
        logic [wid_w-1:0] wid;
        tmask_t           tmask;
        alu_op_e          op;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] rs1;
        logic [reg_w-1:0] rs2;
        logic [reg_w-1:0] rs3;
        logic             use_imm;
        word_t            imm;
    } instr_t;

    // instruction fields plus the per-thread source values
    typedef struct packed {
        logic [wid_w-1:0] wid;
        tmask_t           tmask;
        alu_op_e          op;
        logic [reg_w-1:0] rd;
        logic             use_imm;
        word_t            imm;
        thread_data_t     rs1_data;
        thread_data_t     rs2_data;
        thread_data_t     rs3_data;
    } operands_t;

    typedef struct packed {
        logic [wid_w-1:0] wid;
        tmask_t           tmask;
        logic [reg_w-1:0] rd;
        thread_data_t     data;
    } result_t;

endpackage

`default_nettype wire

//--- common/pipe_if.sv
// pipeline stage interfaces
// issue_if and operands_if are valid/ready streams, writeback_if is
// a valid-only broadcast from the ALU to the register side
`timescale 1ns/1ns
`default_nettype none

interface issue_if;
    import gpu_pkg::*;

    logic   valid;
    logic   ready;
    instr_t data;

    modport master (output valid, output data, input ready);
    modport slave (input valid, input data, output ready);
endinterface

interface operands_if;
    import gpu_pkg::*;

    logic      valid;
    logic      ready;
    operands_t data;

    modport master (output valid, output data, input ready);
    modport slave (input valid, input data, output ready);
endinterface

// no ready here, the register write always completes
interface writeback_if;
    import gpu_pkg::*;

    logic    valid;
    result_t data;

    modport master (output valid, output data);
    modport slave (input valid, input data);
endinterface

`default_nettype wire

//--- operands/gpr_bank.sv
// GPR bank copy
// one write port and one registered, enabled read port over all
// warps, addressed by warp id and register index together
`timescale 1ns/1ns
`default_nettype none

module gpr_bank (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [gpu_pkg::gpr_addr_w-1:0]    wr_addr,
    input  gpu_pkg::word_t                    wr_data,
    input  logic                              rd_en,
    input  logic [gpu_pkg::gpr_addr_w-1:0]    rd_addr,
    output gpu_pkg::word_t                    rd_data
);
    import gpu_pkg::*;

    word_t mem [num_warps*num_regs];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // output holds while the stage is stalled
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- operands/operand_collector.sv
// operand collector
// reads rs1, rs2 and rs3 for every thread from duplicated GPR banks,
// one bank copy per read port, and stages the values together with
// the instruction fields for the ALU one cycle after the accept
`timescale 1ns/1ns
`default_nettype none

module operand_collector (
    input  logic        clk,
    input  logic        reset,
    issue_if.slave      issue,
    writeback_if.slave  wb,
    operands_if.master  operands
);
    import gpu_pkg::*;

    logic                  accept;
    logic                  out_valid;
    instr_t                meta;
    // one read port per source operand
    logic [gpr_addr_w-1:0] rd_addr [3];
    logic [gpr_addr_w-1:0] wr_addr;
    word_t                 rdata [3][num_threads];

    assign issue.ready    = !out_valid || operands.ready;
    assign accept         = issue.valid && issue.ready;
    assign operands.valid = out_valid;

    assign rd_addr[0] = {issue.data.wid, issue.data.rs1};
    assign rd_addr[1] = {issue.data.wid, issue.data.rs2};
    assign rd_addr[2] = {issue.data.wid, issue.data.rs3};
    assign wr_addr    = {wb.data.wid, wb.data.rd};

    // every copy shares the write side and thread j writes only
    // when its mask bit is set
    for (genvar p = 0; p < 3; p++) begin : g_port
        for (genvar j = 0; j < num_threads; j++) begin : g_thread
            gpr_bank gpr_bank_i (
                .clk     (clk),
                .wr_en   (wb.valid && wb.data.tmask[j]),
                .wr_addr (wr_addr),
                .wr_data (wb.data.data[j]),
                .rd_en   (accept),
                .rd_addr (rd_addr[p]),
                .rd_data (rdata[p][j])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (operands.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            meta <= issue.data;
        end
    end

    always_comb begin
        operands.data.wid     = meta.wid;
        operands.data.tmask   = meta.tmask;
        operands.data.op      = meta.op;
        operands.data.rd      = meta.rd;
        operands.data.use_imm = meta.use_imm;
        operands.data.imm     = meta.imm;
        for (int j = 0; j < num_threads; j++) begin
            operands.data.rs1_data[j] = rdata[0][j];
            operands.data.rs2_data[j] = rdata[1][j];
            operands.data.rs3_data[j] = rdata[2][j];
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_scoreboard.sv
// issue scoreboard
// tracks one pending bit per warp and register and stalls any
// instruction whose sources or destination await a write-back;
// passes accepted instructions through with no added latency
`timescale 1ns/1ns
`default_nettype none

module issue_scoreboard (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  gpu_pkg::instr_t in_instr,
    issue_if.master         issue,
    writeback_if.slave      wb
);
    import gpu_pkg::*;

    logic [num_warps-1:0][num_regs-1:0] pending;
    logic                               active;
    logic                               use_rs1;
    logic                               use_rs2;
    logic                               use_rs3;
    logic                               hazard;
    logic                               accept;

    // source usage from the opcode
    assign use_rs1 = (in_instr.op != op_li);
    assign use_rs2 = (in_instr.op == op_madd)
                   || ((in_instr.op != op_li) && !in_instr.use_imm);
    assign use_rs3 = (in_instr.op == op_madd);

    assign hazard = (use_rs1 && pending[in_instr.wid][in_instr.rs1])
                  || (use_rs2 && pending[in_instr.wid][in_instr.rs2])
                  || (use_rs3 && pending[in_instr.wid][in_instr.rs3])
                  || pending[in_instr.wid][in_instr.rd];

    assign issue.valid = active && in_valid && !hazard;
    assign issue.data  = in_instr;
    assign in_ready    = active && issue.ready && !hazard;
    assign accept      = issue.valid && issue.ready;

    // held off for one cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (wb.valid) begin
                pending[wb.data.wid][wb.data.rd] <= 1'b0;
            end
            // a new claim on the same register overrides the release
            if (accept) begin
                pending[in_instr.wid][in_instr.rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu_stage.sv
// ALU stage
// computes a result for every thread and holds it in a one-entry
// output register; the register write-back fires on the result
// handshake so each destination is written exactly once
`timescale 1ns/1ns
`default_nettype none

module alu_stage (
    input  logic             clk,
    input  logic             reset,
    operands_if.slave        operands,
    writeback_if.master      wb,
    output logic             res_valid,
    input  logic             res_ready,
    output gpu_pkg::result_t res
);
    import gpu_pkg::*;

    logic         take;
    thread_data_t alu_out;

    function automatic word_t alu_calc(alu_op_e op, logic use_imm, word_t imm,
                                       word_t a, word_t b_reg, word_t c);
        word_t b;
        word_t r;
        b = use_imm ? imm : b_reg;
        case (op)
            op_li:   r = imm;
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_xor:  r = a ^ b;
            op_mul:  r = a * b;
            // wraps modulo 2^32
            op_madd: r = (a * b_reg) + c;
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        for (int j = 0; j < num_threads; j++) begin
            alu_out[j] = alu_calc(operands.data.op, operands.data.use_imm,
                                  operands.data.imm, operands.data.rs1_data[j],
                                  operands.data.rs2_data[j],
                                  operands.data.rs3_data[j]);
        end
    end

    assign operands.ready = !res_valid || res_ready;
    assign take           = operands.valid && operands.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (take) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res.wid   <= operands.data.wid;
            res.tmask <= operands.data.tmask;
            res.rd    <= operands.data.rd;
            res.data  <= alu_out;
        end
    end

    assign wb.valid = res_valid && res_ready;
    assign wb.data  = res;

endmodule

`default_nettype wire

//--- rtl/warp_core_pipe.sv
// warp core register-read pipeline, top level
// scoreboard, operand collector and ALU chained by stage interfaces,
// with the instruction and result streams exposed as plain ports
`timescale 1ns/1ns
`default_nettype none

module warp_core_pipe (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [gpu_pkg::wid_w-1:0]     in_wid,
    input  gpu_pkg::tmask_t               in_tmask,
    input  gpu_pkg::alu_op_e              in_op,
    input  logic [gpu_pkg::reg_w-1:0]     in_rd,
    input  logic [gpu_pkg::reg_w-1:0]     in_rs1,
    input  logic [gpu_pkg::reg_w-1:0]     in_rs2,
    input  logic [gpu_pkg::reg_w-1:0]     in_rs3,
    input  logic                          in_use_imm,
    input  gpu_pkg::word_t                in_imm,
    output logic                          res_valid,
    input  logic                          res_ready,
    output logic [gpu_pkg::wid_w-1:0]     res_wid,
    output logic [gpu_pkg::reg_w-1:0]     res_rd,
    output gpu_pkg::tmask_t               res_tmask,
    output gpu_pkg::thread_data_t         res_data
);
    import gpu_pkg::*;

    instr_t  in_instr;
    result_t res;

    issue_if     issue ();
    operands_if  operands ();
    writeback_if wb ();

    assign in_instr = '{wid: in_wid, tmask: in_tmask, op: in_op, rd: in_rd,
                        rs1: in_rs1, rs2: in_rs2, rs3: in_rs3,
                        use_imm: in_use_imm, imm: in_imm};

    assign res_wid   = res.wid;
    assign res_rd    = res.rd;
    assign res_tmask = res.tmask;
    assign res_data  = res.data;

    issue_scoreboard issue_scoreboard_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .issue    (issue.master),
        .wb       (wb.slave)
    );

    operand_collector operand_collector_i (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue.slave),
        .wb       (wb.slave),
        .operands (operands.master)
    );

    alu_stage alu_stage_i (
        .clk       (clk),
        .reset     (reset),
        .operands  (operands.slave),
        .wb        (wb.master),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- dv/warp_core_pipe_props.sv
// warp core pipeline assertions
// handshake stability, idle after reset, and no issue of an
// instruction whose destination still awaits its result
`timescale 1ns/1ns
`default_nettype none

module warp_core_pipe_props (
    input logic                          clk,
    input logic                          reset,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic [gpu_pkg::wid_w-1:0]     in_wid,
    input logic [gpu_pkg::reg_w-1:0]     in_rd,
    input gpu_pkg::word_t                in_imm,
    input logic                          res_valid,
    input logic                          res_ready,
    input logic [gpu_pkg::wid_w-1:0]     res_wid,
    input logic [gpu_pkg::reg_w-1:0]     res_rd,
    input gpu_pkg::tmask_t               res_tmask,
    input gpu_pkg::thread_data_t         res_data
);
    import gpu_pkg::*;

    // destinations in flight as seen from the top-level streams
    logic [num_warps-1:0][num_regs-1:0] busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (res_valid && res_ready) begin
                busy[res_wid][res_rd] <= 1'b0;
            end
            if (in_valid && in_ready) begin
                busy[in_wid][in_rd] <= 1'b1;
            end
        end
    end

    res_hold: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_data)
                                    && $stable(res_rd) && $stable(res_wid)
                                    && $stable(res_tmask))
        else $error("result changed before it was taken");

    in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_wid)
                                  && $stable(in_rd) && $stable(in_imm))
        else $error("instruction changed before it was taken");

    reset_idle: assert property (@(posedge clk)
        reset |=> !res_valid && !in_ready)
        else $error("valid or ready high right after reset");

    rd_free: assert property (@(posedge clk) disable iff (reset)
        in_valid && in_ready |-> !busy[in_wid][in_rd])
        else $error("instruction issued while its destination is pending");

endmodule

bind warp_core_pipe warp_core_pipe_props warp_core_pipe_props_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_wid    (in_wid),
    .in_rd     (in_rd),
    .in_imm    (in_imm),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_wid   (res_wid),
    .res_rd    (res_rd),
    .res_tmask (res_tmask),
    .res_data  (res_data)
);

`default_nettype wire

//--- dv/tb_warp_core_pipe.sv
// warp core pipeline testbench
// directed tests against a per-warp, per-thread register model;
// results are checked in issue order as they leave the core
`timescale 1ns/1ns
`default_nettype none

module tb_warp_core_pipe;
    import gpu_pkg::*;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    logic [wid_w-1:0]     in_wid;
    tmask_t               in_tmask;
    alu_op_e              in_op;
    logic [reg_w-1:0]     in_rd;
    logic [reg_w-1:0]     in_rs1;
    logic [reg_w-1:0]     in_rs2;
    logic [reg_w-1:0]     in_rs3;
    logic                 in_use_imm;
    word_t                in_imm;
    logic                 res_valid;
    logic                 res_ready;
    logic [wid_w-1:0]     res_wid;
    logic [reg_w-1:0]     res_rd;
    tmask_t               res_tmask;
    thread_data_t         res_data;

    // register model per warp, register and thread
    word_t       model [num_warps][num_regs][num_threads];
    result_t     exp_q [$];
    result_t     got;
    int          value_errors = 0;
    int          other_errors = 0;
    int          n_issued = 0;
    int          n_checked = 0;
    int          cycles = 0;
    logic        bp_mode;

    warp_core_pipe warp_core_pipe_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_wid     (in_wid),
        .in_tmask   (in_tmask),
        .in_op      (in_op),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_rs3     (in_rs3),
        .in_use_imm (in_use_imm),
        .in_imm     (in_imm),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_wid    (res_wid),
        .res_rd     (res_rd),
        .res_tmask  (res_tmask),
        .res_data   (res_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic word_t alu_ref(input alu_op_e op, input logic use_imm,
                                      input word_t imm, input word_t s1,
                                      input word_t s2, input word_t s3);
        word_t opb;
        opb = s2;
        if (use_imm) begin
            opb = imm;
        end
        case (op)
            op_li:   return imm;
            op_add:  return s1 + opb;
            op_sub:  return s1 - opb;
            op_and:  return s1 & opb;
            op_xor:  return s1 ^ opb;
            op_mul:  return s1 * opb;
            op_madd: return s1 * s2 + s3;
            default: return 'x;
        endcase
    endfunction

    task automatic check_result(input result_t actual, input result_t want);
        if (actual.wid !== want.wid) begin
            $display("[FAIL] res_wid: got %h expected %h", actual.wid, want.wid);
            value_errors++;
        end
        if (actual.rd !== want.rd) begin
            $display("[FAIL] res_rd: got %h expected %h", actual.rd, want.rd);
            value_errors++;
        end
        if (actual.tmask !== want.tmask) begin
            $display("[FAIL] res_tmask: got %h expected %h", actual.tmask, want.tmask);
            value_errors++;
        end
        // threads outside the mask carry no defined value
        for (int j = 0; j < num_threads; j++) begin
            if (want.tmask[j] && actual.data[j] !== want.data[j]) begin
                $display("[FAIL] res_data[%0d] (warp %h, rd %h): got %h expected %h",
                         j, want.wid, want.rd, actual.data[j], want.data[j]);
                value_errors++;
            end
        end
        n_checked++;
    endtask

    // drives one instruction from a falling edge until the DUT accepts it
    task automatic send_instr(input alu_op_e op, input int wid, input tmask_t tmask,
                              input int rd, input int rs1, input int rs2, input int rs3,
                              input logic use_imm, input word_t imm);
        result_t          want;
        logic [wid_w-1:0] w;
        logic [reg_w-1:0] d;
        logic [reg_w-1:0] a;
        logic [reg_w-1:0] b;
        logic [reg_w-1:0] c;
        logic             taken;
        w = wid_w'(wid);
        d = reg_w'(rd);
        a = reg_w'(rs1);
        b = reg_w'(rs2);
        c = reg_w'(rs3);
        want.wid   = w;
        want.tmask = tmask;
        want.rd    = d;
        for (int j = 0; j < num_threads; j++) begin
            want.data[j] = alu_ref(op, use_imm, imm, model[w][a][j], model[w][b][j],
                                   model[w][c][j]);
        end
        for (int j = 0; j < num_threads; j++) begin
            if (tmask[j]) begin
                model[w][d][j] = want.data[j];
            end
        end
        exp_q.push_back(want);
        n_issued++;
        in_valid   = 1'b1;
        in_wid     = w;
        in_tmask   = tmask;
        in_op      = op;
        in_rd      = d;
        in_rs1     = a;
        in_rs2     = b;
        in_rs3     = c;
        in_use_imm = use_imm;
        in_imm     = imm;
        taken      = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic test_load_and_read();
        for (int w = 0; w < num_warps; w++) begin
            for (int r = 0; r < 16; r++) begin
                send_instr(op_li, w, '1, r, 0, 0, 0, 1'b0, $urandom);
            end
        end
        for (int w = 0; w < num_warps; w++) begin
            for (int r = 0; r < 8; r++) begin
                send_instr(op_add, w, '1, r + 16, r, 0, 0, 1'b1, $urandom);
            end
        end
        wait_idle();
    endtask

    task automatic test_alu_ops();
        for (int w = 0; w < num_warps; w++) begin
            for (int k = 1; k <= 5; k++) begin
                send_instr(alu_op_e'(3'(k)), w, '1, 16 + k, 1, 2, 0, 1'b0, 32'h0);
            end
            send_instr(op_madd, w, '1, 22, 3, 4, 5, 1'b0, 32'h0);
        end
        wait_idle();
    endtask

    task automatic test_thread_mask();
        send_instr(op_li, 2, '1, 24, 0, 0, 0, 1'b0, 32'h1111_1111);
        send_instr(op_li, 2, 4'b0101, 24, 0, 0, 0, 1'b0, 32'h2222_2222);
        send_instr(op_add, 2, '1, 25, 24, 0, 0, 1'b1, 32'h0);
        send_instr(op_li, 3, '1, 24, 0, 0, 0, 1'b0, 32'h3333_3333);
        send_instr(op_li, 3, 4'b1010, 24, 0, 0, 0, 1'b0, 32'h4444_4444);
        send_instr(op_add, 3, '1, 25, 24, 0, 0, 1'b1, 32'h0);
        wait_idle();
    endtask

    task automatic test_dependency_chain();
        send_instr(op_li, 0, '1, 26, 0, 0, 0, 1'b0, 32'h0000_0007);
        send_instr(op_li, 0, '1, 27, 0, 0, 0, 1'b0, 32'h0000_0003);
        for (int k = 0; k < 6; k++) begin
            send_instr(op_add, 0, '1, 26, 26, 1, 0, 1'b0, 32'h0);
            send_instr(op_madd, 0, '1, 27, 26, 2, 27, 1'b0, 32'h0);
        end
        wait_idle();
    endtask

    task automatic test_backpressure();
        bp_mode = 1'b1;
        for (int k = 0; k < 40; k++) begin
            send_instr(alu_op_e'(3'(1 + $urandom % 5)), k % 4, '1, 28 + (k / 4) % 2,
                       int'($urandom % 16), int'($urandom % 16), 0,
                       1'($urandom % 2), $urandom);
        end
        wait_idle();
        bp_mode = 1'b0;
    endtask

    task automatic test_warp_isolation();
        for (int w = 0; w < num_warps; w++) begin
            send_instr(op_li, w, '1, 30, 0, 0, 0, 1'b0, 32'hA000_0000 + w);
        end
        for (int w = 0; w < num_warps; w++) begin
            send_instr(op_add, w, '1, 31, 30, 0, 0, 1'b1, 32'h0000_0100);
        end
        wait_idle();
    endtask

    // results are sampled on the edge that takes them
    always @(posedge clk) begin
        if (!reset && res_valid && res_ready) begin
            got.wid   = res_wid;
            got.tmask = res_tmask;
            got.rd    = res_rd;
            got.data  = res_data;
            if (exp_q.size() == 0) begin
                $display("result arrived with no instruction outstanding");
                other_errors++;
            end else begin
                check_result(got, exp_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (bp_mode) begin
            res_ready = ($urandom % 4) != 0;
        end else begin
            res_ready = 1'b1;
        end
    end

    // limit grows with the number of issued instructions
    always @(posedge clk) begin
        cycles++;
        if (cycles > 20 * n_issued + 100) begin
            $display("timeout after %0d cycles, %0d results still outstanding",
                     cycles, exp_q.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h65b6_e396));
        reset      = 1'b1;
        bp_mode    = 1'b0;
        res_ready  = 1'b1;
        in_valid   = 1'b0;
        in_wid     = '0;
        in_tmask   = '0;
        in_op      = op_li;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_rs3     = '0;
        in_use_imm = 1'b0;
        in_imm     = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_load_and_read();
        test_alu_ops();
        test_thread_mask();
        test_dependency_chain();
        test_backpressure();
        test_warp_isolation();
        wait_idle();
        // two cycles drain both stages so a stray extra result is still seen
        repeat (2) @(negedge clk);

        $display("results checked: %0d, value errors: %0d, other errors: %0d",
                 n_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/gpu_pkg.sv
common/pipe_if.sv
operands/gpr_bank.sv
operands/operand_collector.sv
rtl/issue_scoreboard.sv
rtl/alu_stage.sv
rtl/warp_core_pipe.sv
dv/warp_core_pipe_props.sv
dv/tb_warp_core_pipe.sv

//--- run_sim.sh
#!/bin/sh
# build and run the warp core pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_warp_core_pipe -Mdir obj_dir -o sim_warp_core_pipe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_warp_core_pipe > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1
